//--- hdl/sensor_pkg.sv
package sensor_pkg;

    // ####################################################################
    // data widths
    // ####################################################################
    localparam int byte_w = 8;
    localparam int word_w = 16;

    // ####################################################################
    // packet types, upper nibble of a host or reply byte
    // ####################################################################
    localparam logic [3:0] bag_didx   = 4'b0101; // type query.
    localparam logic [3:0] bag_dparam = 4'b0110; // parameter write.
    localparam logic [3:0] bag_ddidx  = 4'b0111; // conversion request.

    localparam logic [3:0] bag_dlink  = 4'b1000; // link up.
    localparam logic [3:0] bag_dtype  = 4'b1001; // type reply.
    localparam logic [3:0] bag_dtemp  = 4'b1010; // parameter reply.
    localparam logic [3:0] bag_data0  = 4'b1101; // conversion reply.

    // ####################################################################
    // adc command codes, first byte of the spi command frame
    // ####################################################################
    localparam logic [7:0] adc_cmd_init = 8'h01;
    localparam logic [7:0] adc_cmd_type = 8'h02;
    localparam logic [7:0] adc_cmd_conf = 8'h03;
    localparam logic [7:0] adc_cmd_conv = 8'h04;

    // The 16-bit response word reads as a type record after a type command
    // and as a temperature record after a conf or conv command.
    typedef union packed {
        struct packed {
            logic [7:0] type_id;
            logic [7:0] revision;
        } type_view;
        struct packed {
            logic [11:0] temp;
            logic [3:0]  status;
        } conv_view;
    } adc_word_t;

endpackage

//--- hdl/uart_rx.sv
`timescale 1ns/1ns

module uart_rx #(
    parameter int clks_per_bit = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rx_line,
    input  logic                          rx_take,
    output logic [sensor_pkg::byte_w-1:0] rx_byte,
    output logic                          rx_ready
);

    localparam int cnt_w = $clog2(clks_per_bit + 1);

    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_start = 2'd1;
    localparam logic [1:0] st_data  = 2'd2;
    localparam logic [1:0] st_stop  = 2'd3;

    logic                          rx_meta;
    logic                          rx_s;
    logic [1:0]                    state;
    logic [cnt_w-1:0]              cnt;
    logic [2:0]                    bit_idx;
    logic [sensor_pkg::byte_w-1:0] shift;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_s    <= 1'b1;
        end else begin
            rx_meta <= rx_line; // two-flop synchronizer.
            rx_s    <= rx_meta;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= st_idle;
            cnt      <= '0;
            bit_idx  <= '0;
            rx_ready <= 1'b0;
        end else begin
            if (rx_take) rx_ready <= 1'b0;
            case (state)
                st_idle: begin
                    cnt <= '0;
                    if (!rx_s) state <= st_start;
                end
                st_start: begin
                    if (cnt == cnt_w'(clks_per_bit / 2 - 1)) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_s ? st_idle : st_data; // glitch check at mid start bit.
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                st_data: begin
                    if (cnt == cnt_w'(clks_per_bit - 1)) begin
                        cnt <= '0;
                        if (bit_idx == 3'd7) state <= st_stop;
                        else bit_idx <= bit_idx + 1'b1;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    if (cnt == cnt_w'(clks_per_bit - 1)) begin
                        state <= st_idle;
                        if (rx_s && !rx_ready) rx_ready <= 1'b1; // drop if still holding.
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_data && cnt == cnt_w'(clks_per_bit - 1))
            shift <= {rx_s, shift[7:1]}; // lsb first.
        if (state == st_stop && cnt == cnt_w'(clks_per_bit - 1) && rx_s && !rx_ready)
            rx_byte <= shift;
    end

endmodule

//--- hdl/uart_tx.sv
`timescale 1ns/1ns

module uart_tx #(
    parameter int clks_per_bit = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          tx_start,
    input  logic [sensor_pkg::byte_w-1:0] tx_byte,
    output logic                          tx_line,
    output logic                          tx_done
);

    localparam int cnt_w = $clog2(clks_per_bit + 1);

    logic             busy;
    logic [cnt_w-1:0] cnt;
    logic [3:0]       bit_idx;
    logic [9:0]       frame;

    assign tx_line = busy ? frame[0] : 1'b1; // idle high.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            cnt     <= '0;
            bit_idx <= '0;
            tx_done <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            if (!busy) begin
                if (tx_start) begin
                    busy    <= 1'b1;
                    cnt     <= '0;
                    bit_idx <= '0;
                end
            end else if (cnt == cnt_w'(clks_per_bit - 1)) begin
                cnt <= '0;
                if (bit_idx == 4'd9) begin
                    busy    <= 1'b0;
                    tx_done <= 1'b1; // end of stop bit.
                end else begin
                    bit_idx <= bit_idx + 1'b1;
                end
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && tx_start)
            frame <= {1'b1, tx_byte, 1'b0}; // stop, data, start.
        else if (busy && cnt == cnt_w'(clks_per_bit - 1))
            frame <= {1'b1, frame[9:1]};
    end

endmodule

//--- hdl/adc_spi_master.sv
`timescale 1ns/1ns

module adc_spi_master #(
    parameter int sclk_div = 2
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          spi_start,
    input  logic [sensor_pkg::word_w-1:0] spi_cmd,
    output logic [sensor_pkg::word_w-1:0] spi_resp,
    output logic                          spi_done,
    output logic                          adc_cs_n,
    output logic                          adc_sclk,
    output logic                          adc_mosi,
    input  logic                          adc_miso
);

    localparam int div_w = $clog2(sclk_div + 1);

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_run  = 2'd1;
    localparam logic [1:0] st_fin  = 2'd2;

    logic [1:0]                    state;
    logic [div_w-1:0]              div_cnt;
    logic [4:0]                    bit_cnt;
    logic [sensor_pkg::word_w-2:0] shift_out;

    // ####################################################################
    // frame control, 16 bits out then 16 bits in under one cs_n low
    // ####################################################################
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= st_idle;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            adc_cs_n <= 1'b1;
            adc_sclk <= 1'b0;
            adc_mosi <= 1'b0;
            spi_done <= 1'b0;
        end else begin
            spi_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (spi_start) begin
                        state    <= st_run;
                        div_cnt  <= '0;
                        bit_cnt  <= '0;
                        adc_cs_n <= 1'b0;
                        adc_mosi <= spi_cmd[15]; // first bit ahead of first rise.
                    end
                end
                st_run: begin
                    if (div_cnt == div_w'(sclk_div - 1)) begin
                        div_cnt  <= '0;
                        adc_sclk <= ~adc_sclk;
                        if (adc_sclk) begin // falling edge.
                            adc_mosi <= (bit_cnt < 5'd15) ? shift_out[14] : 1'b0;
                            if (bit_cnt == 5'd31) state <= st_fin;
                            else bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                default: begin
                    state    <= st_idle;
                    adc_cs_n <= 1'b1;
                    adc_mosi <= 1'b0;
                    spi_done <= 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && spi_start)
            shift_out <= spi_cmd[14:0];
        else if (state == st_run && div_cnt == div_w'(sclk_div - 1)) begin
            if (adc_sclk)
                shift_out <= {shift_out[13:0], 1'b0};
            else if (bit_cnt[4])
                spi_resp <= {spi_resp[14:0], adc_miso}; // sample on rise, msb first.
        end
    end

endmodule

//--- hdl/console_fsm.sv
`timescale 1ns/1ns

module console_fsm (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [sensor_pkg::byte_w-1:0] rx_byte,
    input  logic                          rx_ready,
    output logic                          rx_take,
    output logic                          spi_start,
    output logic [sensor_pkg::word_w-1:0] spi_cmd,
    input  logic [sensor_pkg::word_w-1:0] spi_resp,
    input  logic                          spi_done,
    output logic                          tx_start,
    output logic [sensor_pkg::byte_w-1:0] tx_byte,
    input  logic                          tx_done
);

    // ####################################################################
    // state encoding, group in the upper nibble and step in the lower
    // ####################################################################
    localparam logic [3:0] grp_main  = 4'h0;
    localparam logic [3:0] grp_link  = 4'h1;
    localparam logic [3:0] grp_type  = 4'h2;
    localparam logic [3:0] grp_conf  = 4'h3;
    localparam logic [3:0] step_idle = 4'h0;
    localparam logic [3:0] step_send = 4'h3;
    localparam logic [3:0] step_data = 4'h4;

    localparam logic [7:0] main_idle = 8'h00, main_wait = 8'h01, main_take = 8'h02;
    localparam logic [7:0] link_idle = 8'h10, link_work = 8'h11, link_take = 8'h12;
    localparam logic [7:0] link_send = 8'h13, link_done = 8'h15;
    localparam logic [7:0] type_idle = 8'h20, type_work = 8'h21, type_take = 8'h22;
    localparam logic [7:0] type_send = 8'h23, type_data = 8'h24, type_done = 8'h25;
    localparam logic [7:0] conf_idle = 8'h30, conf_work = 8'h31, conf_take = 8'h32;
    localparam logic [7:0] conf_send = 8'h33, conf_data = 8'h34, conf_done = 8'h35;
    localparam logic [7:0] conv_idle = 8'h40, conv_work = 8'h41, conv_take = 8'h42;
    localparam logic [7:0] conv_send = 8'h43, conv_data = 8'h44, conv_done = 8'h45;

    logic [7:0]                    state;
    logic [7:0]                    next_state;
    logic [3:0]                    req_type;
    logic [3:0]                    req_data;
    logic [7:0]                    cmd_code;
    logic [sensor_pkg::byte_w-1:0] head_byte;
    logic [sensor_pkg::byte_w-1:0] data_byte;
    sensor_pkg::adc_word_t         resp_w;

    assign resp_w = spi_resp;

    assign rx_take   = (state == main_take);
    assign spi_start = (state[3:0] == step_idle) && (state[7:4] != grp_main);
    assign tx_byte   = (state[3:0] == step_data) ? data_byte : head_byte;

    always_comb begin
        case (state[7:4])
            grp_link: cmd_code = sensor_pkg::adc_cmd_init;
            grp_type: cmd_code = sensor_pkg::adc_cmd_type;
            grp_conf: cmd_code = sensor_pkg::adc_cmd_conf;
            default:  cmd_code = sensor_pkg::adc_cmd_conv;
        endcase
        spi_cmd = {cmd_code, 4'h0, (state[7:4] == grp_link) ? 4'h0 : req_data};
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= main_idle;
            tx_start <= 1'b0;
        end else begin
            state    <= next_state;
            tx_start <= (next_state != state) &&
                        (next_state[3:0] == step_send || next_state[3:0] == step_data);
        end
    end

    // ####################################################################
    // next state
    // ####################################################################
    always_comb begin
        next_state = state;
        case (state)
            main_idle: next_state = link_idle;
            main_wait: if (rx_ready) next_state = main_take;
            main_take: begin
                if (req_type == sensor_pkg::bag_didx) next_state = type_idle;
                else if (req_type == sensor_pkg::bag_dparam) next_state = conf_idle;
                else if (req_type == sensor_pkg::bag_ddidx) next_state = conv_idle;
                else next_state = main_wait; // unknown type, byte dropped.
            end

            link_idle: next_state = link_work;
            link_work: if (spi_done) next_state = link_take;
            link_take: next_state = link_send;
            link_send: if (tx_done) next_state = link_done;
            link_done: next_state = main_wait;

            type_idle: next_state = type_work;
            type_work: if (spi_done) next_state = type_take;
            type_take: next_state = type_send;
            type_send: if (tx_done) next_state = type_data;
            type_data: if (tx_done) next_state = type_done;
            type_done: next_state = main_wait;

            conf_idle: next_state = conf_work;
            conf_work: if (spi_done) next_state = conf_take;
            conf_take: next_state = conf_send;
            conf_send: if (tx_done) next_state = conf_data;
            conf_data: if (tx_done) next_state = conf_done;
            conf_done: next_state = main_wait;

            conv_idle: next_state = conv_work;
            conv_work: if (spi_done) next_state = conv_take;
            conv_take: next_state = conv_send;
            conv_send: if (tx_done) next_state = conv_data;
            conv_data: if (tx_done) next_state = conv_done;
            conv_done: next_state = main_wait;

            default: next_state = main_idle;
        endcase
    end

    // request nibbles and reply bytes
    always_ff @(posedge clk) begin
        if (state == main_wait && rx_ready) begin
            req_type <= rx_byte[7:4];
            req_data <= rx_byte[3:0];
        end
        case (state)
            link_take: head_byte <= {sensor_pkg::bag_dlink, 4'h0};
            type_take: begin
                head_byte <= {sensor_pkg::bag_dtype, req_data}; // echo index.
                data_byte <= resp_w.type_view.type_id;
            end
            conf_take: begin
                head_byte <= {sensor_pkg::bag_dtemp, 4'h0};
                data_byte <= resp_w.conv_view.temp[11:4];
            end
            conv_take: begin
                head_byte <= {sensor_pkg::bag_data0, resp_w.conv_view.status};
                data_byte <= resp_w.conv_view.temp[11:4];
            end
            default: ;
        endcase
    end

endmodule

//--- hdl/sensor_console.sv
`timescale 1ns/1ns

module sensor_console #(
    parameter int clks_per_bit = 8,
    parameter int sclk_div     = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic rx_line,
    output logic tx_line,
    output logic adc_cs_n,
    output logic adc_sclk,
    output logic adc_mosi,
    input  logic adc_miso
);

    logic [sensor_pkg::byte_w-1:0] rx_byte;
    logic                          rx_ready;
    logic                          rx_take;
    logic [sensor_pkg::byte_w-1:0] tx_byte;
    logic                          tx_start;
    logic                          tx_done;
    logic [sensor_pkg::word_w-1:0] spi_cmd;
    logic [sensor_pkg::word_w-1:0] spi_resp;
    logic                          spi_start;
    logic                          spi_done;

    // ####################################################################
    // host link
    // ####################################################################
    uart_rx #(.clks_per_bit(clks_per_bit)) i_uart_rx (
        .clk(clk), .rst(rst), .rx_line(rx_line), .rx_take(rx_take),
        .rx_byte(rx_byte), .rx_ready(rx_ready)
    );

    uart_tx #(.clks_per_bit(clks_per_bit)) i_uart_tx (
        .clk(clk), .rst(rst), .tx_start(tx_start), .tx_byte(tx_byte),
        .tx_line(tx_line), .tx_done(tx_done)
    );

    // ####################################################################
    // adc link and sequencer
    // ####################################################################
    adc_spi_master #(.sclk_div(sclk_div)) i_adc_spi_master (
        .clk(clk), .rst(rst), .spi_start(spi_start), .spi_cmd(spi_cmd),
        .spi_resp(spi_resp), .spi_done(spi_done), .adc_cs_n(adc_cs_n),
        .adc_sclk(adc_sclk), .adc_mosi(adc_mosi), .adc_miso(adc_miso)
    );

    console_fsm i_console_fsm (
        .clk(clk), .rst(rst), .rx_byte(rx_byte), .rx_ready(rx_ready),
        .rx_take(rx_take), .spi_start(spi_start), .spi_cmd(spi_cmd),
        .spi_resp(spi_resp), .spi_done(spi_done), .tx_start(tx_start),
        .tx_byte(tx_byte), .tx_done(tx_done)
    );

endmodule

//--- testbench/sensor_console_properties.sv
`timescale 1ns/1ns

module sensor_console_properties (
    input logic clk,
    input logic rst,
    input logic tx_line,
    input logic adc_cs_n,
    input logic adc_sclk
);

    // ####################################################################
    // adc pins
    // ####################################################################
    assert property (@(posedge clk) adc_cs_n |-> !adc_sclk)
        else $error("adc_sclk is high while adc_cs_n is high");

    // no frame in the first two cycles after reset is released.
    assert property (@(posedge clk) ($past(rst) || $past(rst, 2)) |-> adc_cs_n)
        else $error("adc_cs_n went low right after reset");

    // ####################################################################
    // host pins
    // ####################################################################
    assert property (@(posedge clk) (rst && $past(rst)) |-> tx_line)
        else $error("tx_line is low during reset");

endmodule

bind sensor_console sensor_console_properties i_sensor_console_properties (
    .clk(clk), .rst(rst), .tx_line(tx_line), .adc_cs_n(adc_cs_n), .adc_sclk(adc_sclk)
);

//--- testbench/sensor_console_tb.sv
`timescale 1ns/1ns

module sensor_console_tb;

    localparam int clks_per_bit = 8;
    localparam int sclk_div     = 2;
    localparam int byte_clks    = 10 * clks_per_bit;
    localparam int frame_clks   = 32 * 2 * sclk_div + 2;
    localparam int max_cases    = 32;

    logic clk = 1'b0;
    logic rst;
    logic rx_line;
    logic tx_line;
    logic adc_cs_n;
    logic adc_sclk;
    logic adc_mosi;
    logic adc_miso;

    logic [7:0]  case_req     [0:max_cases-1];
    logic [15:0] case_resp    [0:max_cases-1];
    logic [15:0] case_cmd     [0:max_cases-1];
    logic        case_has_cmd [0:max_cases-1];
    int          case_nrep    [0:max_cases-1];
    logic [7:0]  case_reply   [0:max_cases-1][0:1];
    int          case_count;

    logic [15:0] cur_resp;    // word the adc model returns.
    logic [15:0] frame_q [$]; // command words seen by the adc model.
    logic [9:0]  reply_q [$]; // stop bit, start bit, data byte.
    int          replies_taken;
    int          error_count;
    int          cycle_cnt = 0;
    int          cycle_limit;

    always #20 clk = ~clk;

    sensor_console #(.clks_per_bit(clks_per_bit), .sclk_div(sclk_div)) i_sensor_console (
        .clk(clk), .rst(rst), .rx_line(rx_line), .tx_line(tx_line), .adc_cs_n(adc_cs_n),
        .adc_sclk(adc_sclk), .adc_mosi(adc_mosi), .adc_miso(adc_miso)
    );

    task automatic check_equal(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h",
                     $time, what, got, expected);
            $display("Some tests failed");
            $fatal(1, "stopped at the first failed check");
        end
    endtask

    function automatic logic [15:0] parse_hex_word(input logic [31:0] tok);
        logic [15:0] val;
        logic [7:0]  ch;
        val = '0;
        for (int i = 3; i >= 0; i--) begin
            ch = tok[i*8 +: 8];
            if (ch >= "a") ch = ch - 8'd87;
            else if (ch >= "A") ch = ch - 8'd55;
            else ch = ch - 8'd48;
            val = {val[11:0], ch[3:0]};
        end
        return val;
    endfunction

    task automatic load_cases();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  req;
        logic [15:0] resp;
        logic [31:0] cmd_tok;
        int          nrep;
        logic [7:0]  b0;
        logic [7:0]  b1;
        case_count = 0;
        fd = $fopen("testbench/sensor_console_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open the case file testbench/sensor_console_cases.txt");
            $display("Some tests failed");
            $fatal(1, "case file missing");
        end else begin
            while (!$feof(fd) && case_count < max_cases) begin
                n = $fgets(line, fd);
                if (n > 0 && $sscanf(line, "%h %h %s %d %h %h",
                                     req, resp, cmd_tok, nrep, b0, b1) == 6) begin
                    case_req[case_count]      = req;
                    case_resp[case_count]     = resp;
                    case_has_cmd[case_count]  = (cmd_tok != "none");
                    case_cmd[case_count]      = parse_hex_word(cmd_tok);
                    case_nrep[case_count]     = nrep;
                    case_reply[case_count][0] = b0;
                    case_reply[case_count][1] = b1;
                    case_count++;
                end
            end
            $fclose(fd);
            if (case_count == 0) begin
                $display("the case file holds no records");
                $display("Some tests failed");
                $fatal(1, "empty case file");
            end
        end
    endtask

    // 8N1 frame, lsb first.
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] bits;
        bits = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx_line <= bits[i];
            repeat (clks_per_bit - 1) @(posedge clk);
        end
        @(posedge clk);
    endtask

    task automatic run_case(input int idx, input logic send_req);
        int         frames_before;
        int         quiet;
        logic [9:0] got;
        frames_before = frame_q.size();
        cur_resp = case_resp[idx];
        if (send_req) send_byte(case_req[idx]);
        while (reply_q.size() < replies_taken + case_nrep[idx]) @(posedge clk);
        quiet = byte_clks + 4;
        if (case_nrep[idx] == 0) quiet = quiet + frame_clks + byte_clks; // room for a stray frame.
        repeat (quiet) @(posedge clk);
        check_equal(32'(frame_q.size() - frames_before), case_has_cmd[idx] ? 32'd1 : 32'd0,
                    $sformatf("case %0d adc frame count", idx));
        if (case_has_cmd[idx])
            check_equal(32'(frame_q[frames_before]), 32'(case_cmd[idx]),
                        $sformatf("case %0d adc command word", idx));
        check_equal(32'(reply_q.size() - replies_taken), 32'(case_nrep[idx]),
                    $sformatf("case %0d reply byte count", idx));
        for (int k = 0; k < case_nrep[idx]; k++) begin
            got = reply_q[replies_taken + k];
            check_equal(32'(got[9:8]), 32'd2, $sformatf("case %0d reply %0d framing", idx, k));
            check_equal(32'(got[7:0]), 32'(case_reply[idx][k]),
                        $sformatf("case %0d reply byte %0d", idx, k));
        end
        replies_taken = replies_taken + case_nrep[idx];
    endtask

    // ####################################################################
    // adc model, spi mode 0, command in then response out
    // ####################################################################
    initial begin : adc_model
        logic        cs_prev;
        logic        sclk_prev;
        logic [15:0] cmd_bits;
        int          rise_cnt;
        adc_miso  = 1'b0;
        cs_prev   = 1'b1;
        sclk_prev = 1'b0;
        cmd_bits  = '0;
        rise_cnt  = 0;
        forever begin
            @(posedge clk);
            if (!rst) begin
                if (cs_prev && !adc_cs_n) begin
                    rise_cnt = 0;
                    cmd_bits = '0;
                end
                if (!adc_cs_n && !sclk_prev && adc_sclk) begin
                    if (rise_cnt < 16) cmd_bits = {cmd_bits[14:0], adc_mosi};
                    rise_cnt++;
                end
                if (!adc_cs_n && sclk_prev && !adc_sclk && rise_cnt >= 16 && rise_cnt < 32)
                    adc_miso <= cur_resp[31 - rise_cnt]; // msb first, ready before next rise.
                if (!cs_prev && adc_cs_n) frame_q.push_back(cmd_bits);
            end
            cs_prev   = rst ? 1'b1 : adc_cs_n;
            sclk_prev = rst ? 1'b0 : adc_sclk;
        end
    end

    // uart monitor, samples each bit near its middle.
    initial begin : uart_monitor
        logic [7:0] data;
        logic       start_bit;
        logic       stop_bit;
        forever begin
            @(posedge clk);
            if (tx_line === 1'b0) begin
                repeat (clks_per_bit / 2) @(posedge clk);
                start_bit = tx_line;
                for (int i = 0; i < 8; i++) begin
                    repeat (clks_per_bit) @(posedge clk);
                    data[i] = tx_line;
                end
                repeat (clks_per_bit) @(posedge clk);
                stop_bit = tx_line;
                reply_q.push_back({stop_bit, start_bit, data});
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout, the cases did not finish within %0d cycles", cycle_limit);
            $display("Some tests failed");
            $fatal(1, "timeout");
        end
    end

    // ####################################################################
    // main sequence
    // ####################################################################
    initial begin : main_seq
        int gap;
        rst           = 1'b1;
        rx_line       = 1'b1;
        cur_resp      = '0;
        error_count   = 0;
        replies_taken = 0;
        void'($urandom(32'hf0378266));
        load_cases();
        cycle_limit = (case_count + 1) * 600;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        run_case(0, 1'b0); // link packet, nothing sent.
        for (int i = 1; i < case_count; i++) begin
            gap = $urandom % 41;
            repeat (gap) @(posedge clk);
            run_case(i, 1'b1);
        end
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- testbench/sensor_console_cases.txt
# columns: request, adc response, expected command or none, reply count, reply byte 0, byte 1
# all hex except the reply count; the first record is the link packet and its request is not sent
00 1234 0100 1 80 00
53 A55A 0203 2 93 A5
50 3C01 0200 2 90 3C
5F FF00 020F 2 9F FF
64 7B2C 0304 2 A0 7B
69 1E65 0309 2 A0 1E
72 5A39 0402 2 D9 5A
70 0000 0400 2 D0 00
7F FFFF 040F 2 DF FF
35 0000 none 0 00 00
75 C4D6 0405 2 D6 C4
F1 0000 none 0 00 00
57 8E21 0207 2 97 8E
7A 0F3F 040A 2 DF 0F
60 FFF0 0300 2 A0 FF
00 0000 none 0 00 00
6F 8001 030F 2 A0 80

//--- sensor_console.f
hdl/sensor_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/adc_spi_master.sv
hdl/console_fsm.sv
hdl/sensor_console.sv
testbench/sensor_console_properties.sv
testbench/sensor_console_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the sensor console testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module sensor_console_tb -f sensor_console.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vsensor_console_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit 1
fi

if echo "$out" | grep -q "^All tests passed$"; then
    exit 0
fi
echo "pass message not found in the simulation output"
exit 1
